/* sim.f */
+incdir+logic
logic/snd_pkg.sv
logic/snd_bus_decode.sv
logic/snd_sys_regs.sv
logic/snd_work_ram.sv
logic/snd_dc_block.sv
logic/snd_mixer.sv
logic/snd_board.sv
bench/snd_board_sva.sv
bench/snd_board_tb.sv

/* Bender.yml */
package:
  name: snd_board

sources:
  - include_dirs:
      - logic
    files:
      - logic/snd_pkg.sv
      - logic/snd_bus_decode.sv
      - logic/snd_sys_regs.sv
      - logic/snd_work_ram.sv
      - logic/snd_dc_block.sv
      - logic/snd_mixer.sv
      - logic/snd_board.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/snd_board_sva.sv
      - bench/snd_board_tb.sv

/* bench/snd_board_tb.sv */
// directed sound board bench; CPU and chips are port drives and psg stays 0 before the dc test
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_board_tb;
    localparam int dc_strobes     = 600;
    localparam int psg_level      = 512;                      // constant psg for the dc test
    localparam int timeout_cycles = dc_strobes * 4 + 1600;    // dc test dominates

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               cen_opn = 1'b0, cen_opl = 1'b0, snreq = 1'b0;
    logic               cpu_rnw = 1'b1, rom_ok = 1'b1, opn_irqn = 1'b1, opl_irqn = 1'b1;
    snd_pkg::cpu_addr_t cpu_addr = 16'h2000;                  // unmapped hole
    snd_pkg::cpu_data_t latch = '0, cpu_dout = '0, rom_data = '0;
    snd_pkg::cpu_data_t opn_dout = '0, opl_dout = '0, oki_dout = '0;
    snd_pkg::sample_t   opn_snd = '0, opl_snd = '0, adpcm_snd = '0;
    snd_pkg::psg_t      psg_snd = '0;
    snd_pkg::cpu_data_t cpu_din;
    snd_pkg::cpu_addr_t rom_addr;
    snd_pkg::sample_t   snd;
    logic rdy, nmin, irqn, rom_cs, snd_bank, opn_cs, opl_cs, oki_wrn, cen_oki, sample, peak;
    int seed   = 32'ha5d86ef3;
    int errors = 0;
    int cycles = 0;
    int phase  = 0;

    snd_board i_snd_board (.*);

    bind snd_board snd_board_sva i_snd_board_sva (.*);

    always #5 clk = ~clk;

    // free running enables with opn every 4 clocks and opl every 2
    always @(negedge clk) begin
        phase   = phase + 1;
        cen_opn = (phase % 4) == 0;
        cen_opl = (phase % 2) == 0;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_data(input string name, input snd_pkg::cpu_data_t got,
                              input snd_pkg::cpu_data_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input snd_pkg::cpu_addr_t got,
                              input snd_pkg::cpu_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_sample(input string name, input snd_pkg::sample_t got,
                                input snd_pkg::sample_t exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // new bus cycle on the falling edge and comb outputs settled on return
    task automatic drive_bus(input snd_pkg::cpu_addr_t addr, input logic rnw,
                             input snd_pkg::cpu_data_t data);
        @(negedge clk);
        cpu_addr = addr;
        cpu_rnw  = rnw;
        cpu_dout = data;
        #1;
    endtask

    task automatic settle_next();
        @(negedge clk);
        #1;
    endtask

    // returns on the rising edge that carried cen_opn
    task automatic wait_strobe();
        do begin
            @(posedge clk);
        end while (cen_opn !== 1'b1);
    endtask

    // 4.4 gains with the fraction dropped by an arithmetic shift
    function automatic int mix_value(input int a, input int b, input int c, input int d);
        int acc;
        acc = a * int'(`SND_OPN_GAIN) + b * int'(`SND_OPL_GAIN)
            + c * int'(`SND_PCM_GAIN) + d * int'(`SND_PSG_GAIN);
        return acc >>> 4;
    endfunction

    function automatic snd_pkg::sample_t clamp16(input int v);
        if (v > 32767) return 16'sh7fff;
        if (v < -32768) return 16'sh8000;
        return 16'(v);
    endfunction

    task automatic select_is(input snd_pkg::cpu_addr_t addr, input logic rom, input logic opn,
                             input logic opl);
        drive_bus(addr, 1'b1, 8'h00);
        check_bit("rom_cs", rom_cs, rom);
        check_bit("opn_cs", opn_cs, opn);
        check_bit("opl_cs", opl_cs, opl);
        check_bit("oki_wrn", oki_wrn, 1'b1);   // reads never strobe the ADPCM
        check_addr("rom_addr", rom_addr, addr);
    endtask

    task automatic decode_map();
        select_is(16'h0123, 1'b0, 1'b0, 1'b0);   // ram
        select_is(16'h0a00, 1'b0, 1'b1, 1'b0);
        select_is(16'h1400, 1'b0, 1'b0, 1'b1);
        select_is(16'h3000, 1'b0, 1'b0, 1'b0);   // latch
        select_is(16'h3900, 1'b0, 1'b0, 1'b0);   // adpcm
        select_is(16'h2800, 1'b0, 1'b0, 1'b0);   // hole
        select_is(16'h4000, 1'b1, 1'b0, 1'b0);
        select_is(16'hf00f, 1'b1, 1'b0, 1'b0);
        drive_bus(16'h3800, 1'b0, 8'h5a);
        check_bit("oki_wrn", oki_wrn, 1'b0);
        @(negedge clk);
        rom_ok   = 1'b0;
        cpu_addr = 16'hc123;
        cpu_rnw  = 1'b1;
        #1 check_bit("rdy", rdy, 1'b0);
        drive_bus(16'h0123, 1'b1, 8'h00);        // ram never stalls
        check_bit("rdy", rdy, 1'b1);
        @(negedge clk);
        rom_ok = 1'b1;
    endtask

    task automatic read_back();
        snd_pkg::cpu_addr_t addr [8];
        snd_pkg::cpu_data_t data [8];
        for (int i = 0; i < 8; i++) begin
            addr[i] = {5'b0, 8'($random(seed)), 3'(i)};   // distinct ram bytes
            data[i] = 8'($random(seed));
            drive_bus(addr[i], 1'b0, data[i]);
        end
        for (int i = 0; i < 8; i++) begin
            drive_bus(addr[i], 1'b1, 8'h00);
            settle_next();
            check_data("cpu_din ram", cpu_din, data[i]);
        end
        @(negedge clk);
        latch    = 8'($random(seed));
        opn_dout = 8'($random(seed));
        opl_dout = 8'($random(seed));
        oki_dout = 8'($random(seed));
        rom_data = 8'($random(seed));
        drive_bus(16'h3000, 1'b1, 8'h00);
        check_data("cpu_din latch", cpu_din, latch);
        drive_bus(16'h0800, 1'b1, 8'h00);
        settle_next();
        check_data("cpu_din opn", cpu_din, opn_dout);
        drive_bus(16'h1000, 1'b1, 8'h00);
        settle_next();
        check_data("cpu_din opl", cpu_din, opl_dout);
        drive_bus(16'h3800, 1'b1, 8'h00);
        settle_next();
        check_data("cpu_din oki", cpu_din, oki_dout);
        drive_bus(16'h9abc, 1'b1, 8'h00);        // same cycle pass through
        check_data("cpu_din rom", cpu_din, rom_data);
        drive_bus(16'h1800, 1'b1, 8'h00);
        settle_next();
        check_data("cpu_din open", cpu_din, 8'hff);
        drive_bus(16'h3000, 1'b0, 8'h00);        // latch write decodes to nothing
        settle_next();
        check_data("cpu_din open", cpu_din, 8'hff);
    endtask

    task automatic nmi_sequence();
        drive_bus(16'h2000, 1'b1, 8'h00);
        @(negedge clk);
        snreq = 1'b1;
        settle_next();
        check_bit("nmin", nmin, 1'b0);
        drive_bus(16'h3000, 1'b1, 8'h00);        // latch read acks
        drive_bus(16'h2000, 1'b1, 8'h00);
        check_bit("nmin", nmin, 1'b1);
        repeat (3) settle_next();
        check_bit("nmin", nmin, 1'b1);           // held level gives no new request
        @(negedge clk);
        snreq = 1'b0;
        settle_next();
        @(negedge clk);
        snreq = 1'b1;
        settle_next();
        check_bit("nmin", nmin, 1'b0);
        drive_bus(16'h3000, 1'b1, 8'h00);
        @(negedge clk);
        snreq    = 1'b0;
        cpu_addr = 16'h2000;
        #1 check_bit("nmin", nmin, 1'b1);
    endtask

    task automatic bank_and_irq();
        drive_bus(16'h8000, 1'b0, 8'h01);
        drive_bus(16'h2000, 1'b1, 8'h00);
        check_bit("snd_bank", snd_bank, 1'b1);
        drive_bus(16'h4000, 1'b0, 8'h00);        // rom space with bit 15 clear
        drive_bus(16'h2000, 1'b1, 8'h00);
        check_bit("snd_bank", snd_bank, 1'b1);
        drive_bus(16'hffff, 1'b0, 8'hfe);
        drive_bus(16'h2000, 1'b1, 8'h00);
        check_bit("snd_bank", snd_bank, 1'b0);
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            opn_irqn = i[0];
            opl_irqn = i[1];
            #1 check_bit("irqn", irqn, i[0] & i[1]);
        end
    endtask

    task automatic mix_case(input int a, input int b, input int c);
        int v;
        @(negedge clk);
        opn_snd   = 16'(a);
        opl_snd   = 16'(b);
        adpcm_snd = 16'(c);
        wait_strobe();
        settle_next();
        v = mix_value(int'(opn_snd), int'(opl_snd), int'(adpcm_snd), 0);
        check_sample("snd", snd, clamp16(v));
        check_bit("peak", peak, v > 32767 || v < -32768);
    endtask

    task automatic mixer_sums();
        mix_case(100, -50, 7);
        mix_case(28672, 28672, 28672);           // clips high
        mix_case(-28672, -28672, -28672);        // clips low
        repeat (6) mix_case($random(seed), $random(seed), $random(seed));
        mix_case(0, 0, 0);
    endtask

    task automatic oki_and_dc();
        int opl_seen;
        int oki_seen;
        int avg;
        int dc;
        int last_dc;
        opl_seen = 0;
        oki_seen = 0;
        repeat (60) begin
            settle_next();
            check_bit("sample", sample, cen_opn);
            if (cen_oki) begin
                if (oki_seen > 0 && opl_seen != `SND_OKI_DIV) begin
                    errors++;
                    $display("cen_oki pulsed after %0d cen_opl strobes", opl_seen);
                end
                oki_seen++;
                opl_seen = 0;
            end
            if (cen_opl) opl_seen++;
        end
        if (oki_seen < 9) begin
            errors++;
            $display("cen_oki pulsed only %0d times in 60 clocks", oki_seen);
        end
        avg     = 0;
        last_dc = 0;
        @(negedge clk);
        psg_snd = 10'(psg_level);
        for (int k = 0; k < dc_strobes; k++) begin
            wait_strobe();
            settle_next();
            check_sample("snd", snd, clamp16(mix_value(0, 0, 0, last_dc)));
            dc      = (psg_level << `SND_PSG_SCALE) - avg;   // filter output this strobe
            avg     = avg + ((dc + (1 << (`SND_DC_SHIFT - 1))) >>> `SND_DC_SHIFT);
            last_dc = dc;                                    // mixed one strobe later
        end
        if (snd >= 32 || snd <= -32) begin
            errors++;
            $display("psg contribution %0d did not decay below 32", snd);
        end
    endtask

    initial begin
        repeat (3) @(negedge clk);
        rst = 1'b0;
        decode_map();
        read_back();
        nmi_sequence();
        bank_and_irq();
        mixer_sums();
        oki_and_dc();
        repeat (2) @(negedge clk);
        $display("result: %0d compare errors, %0d assertion errors", errors,
                 i_snd_board.i_snd_board_sva.assert_errors);
        if (errors == 0 && i_snd_board.i_snd_board_sva.assert_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* bench/snd_board_sva.sv */
// bound into the board top; sees the internal ADPCM select, assumes rst is high at time zero
`timescale 1ns/1ps

module snd_board_sva (
    input logic             clk,
    input logic             rst,
    input logic             rom_cs,
    input logic             opn_cs,
    input logic             opl_cs,
    input logic             oki_cs,
    input logic             cen_oki,
    input logic             nmin,
    input logic             peak,
    input snd_pkg::sample_t snd
);
    int assert_errors = 0;   // failure count, picked up by the bench

    a_one_cs: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, opn_cs, opl_cs, oki_cs}))
        else begin
            assert_errors++;
            $error("more than one chip select active");
        end

    // adpcm enable is a single clock strobe
    a_oki_pulse: assert property (@(posedge clk) disable iff (rst) cen_oki |=> !cen_oki)
        else begin
            assert_errors++;
            $error("cen_oki high on two clocks in a row");
        end

    a_nmin_reset: assert property (@(posedge clk) $fell(rst) |-> nmin)
        else begin
            assert_errors++;
            $error("nmin low on the first clock after reset");
        end

    a_peak_full: assert property (@(posedge clk) disable iff (rst)
        peak |-> (snd == 16'sh7fff || snd == 16'sh8000))
        else begin
            assert_errors++;
            $error("peak set while snd is not at full scale");
        end

endmodule

/* logic/snd_board.sv */
// sound board glue without CPU and chips; the 6502 must honour rdy, chips sit on the ports
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_board #(
    parameter bit has_bank = 1'b1     // banked ROM boards only
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen_opn,     // also the audio sample rate
    input  logic               cen_opl,
    input  logic               snreq,
    input  snd_pkg::cpu_data_t latch,
    input  snd_pkg::cpu_addr_t cpu_addr,
    input  snd_pkg::cpu_data_t cpu_dout,
    input  logic               cpu_rnw,
    input  snd_pkg::cpu_data_t rom_data,
    input  logic               rom_ok,
    input  snd_pkg::cpu_data_t opn_dout,
    input  snd_pkg::cpu_data_t opl_dout,
    input  snd_pkg::cpu_data_t oki_dout,
    input  logic               opn_irqn,
    input  logic               opl_irqn,
    input  snd_pkg::sample_t   opn_snd,
    input  snd_pkg::sample_t   opl_snd,
    input  snd_pkg::sample_t   adpcm_snd,   // already upsampled
    input  snd_pkg::psg_t      psg_snd,
    output snd_pkg::cpu_data_t cpu_din,
    output logic               rdy,
    output logic               nmin,
    output logic               irqn,
    output snd_pkg::cpu_addr_t rom_addr,
    output logic               rom_cs,
    output logic               snd_bank,
    output logic               opn_cs,
    output logic               opl_cs,
    output logic               oki_wrn,
    output logic               cen_oki,
    output snd_pkg::sample_t   snd,
    output logic               sample,
    output logic               peak
);
    snd_pkg::cpu_data_t ram_dout;
    snd_pkg::sample_t   psg_ac;     // psg with dc removed
    logic               ram_we;
    logic               oki_cs;     // ADPCM select, the chip only sees oki_wrn
    logic               nmi_clr;
    logic               bank_we;

    assign irqn     = opn_irqn & opl_irqn;   // shared irq line
    assign rom_addr = cpu_addr;              // bank applied outside
    assign sample   = cen_opn;

    snd_bus_decode i_snd_bus_decode (
        .clk      (clk),       .rst     (rst),
        .cpu_addr (cpu_addr),  .cpu_rnw (cpu_rnw),
        .rom_data (rom_data),  .ram_dout(ram_dout),
        .latch    (latch),     .opn_dout(opn_dout),
        .opl_dout (opl_dout),  .oki_dout(oki_dout),
        .rom_ok   (rom_ok),    .has_bank(1'(has_bank)),
        .cpu_din  (cpu_din),   .rom_cs  (rom_cs),
        .ram_we   (ram_we),    .opn_cs  (opn_cs),
        .opl_cs   (opl_cs),    .oki_cs  (oki_cs),
        .oki_wrn  (oki_wrn),   .nmi_clr (nmi_clr),
        .bank_we  (bank_we),   .rdy     (rdy)
    );

    snd_sys_regs i_snd_sys_regs (
        .clk      (clk),       .rst     (rst),
        .snreq    (snreq),     .nmi_clr (nmi_clr),
        .bank_we  (bank_we),   .bank_din(cpu_dout[0]),   // bank in bit 0
        .cen_opl  (cen_opl),   .nmin    (nmin),
        .snd_bank (snd_bank),  .cen_oki (cen_oki)
    );

    snd_work_ram i_snd_work_ram (
        .clk  (clk),
        .addr (cpu_addr[`SND_RAM_AW-1:0]),  // mirrors inside the region
        .din  (cpu_dout),
        .we   (ram_we),
        .dout (ram_dout)
    );

    snd_dc_block i_snd_dc_block (
        .clk (clk), .rst (rst), .sample (cen_opn), .din (psg_snd), .dout (psg_ac)
    );

    snd_mixer i_snd_mixer (
        .clk  (clk),       .rst (rst),      .cen (cen_opn),
        .ch0  (opn_snd),   .ch1 (opl_snd),
        .ch2  (adpcm_snd), .ch3 (psg_ac),
        .mixed(snd),       .peak(peak)
    );

endmodule

/* logic/snd_mixer.sv */
// fixed gain four channel mixer; gains come from the macros, output saturates to 16 bits
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_mixer (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,      // sample strobe
    input  snd_pkg::sample_t ch0,      // opn fm
    input  snd_pkg::sample_t ch1,      // opl fm
    input  snd_pkg::sample_t ch2,      // adpcm
    input  snd_pkg::sample_t ch3,      // psg after dc removal
    output snd_pkg::sample_t mixed,
    output logic             peak      // this sample was clipped
);
    localparam snd_pkg::gain_t gain0 = `SND_OPN_GAIN;
    localparam snd_pkg::gain_t gain1 = `SND_OPL_GAIN;
    localparam snd_pkg::gain_t gain2 = `SND_PCM_GAIN;
    localparam snd_pkg::gain_t gain3 = `SND_PSG_GAIN;

    logic signed [24:0] prod0;
    logic signed [24:0] prod1;
    logic signed [24:0] prod2;
    logic signed [24:0] prod3;
    logic signed [26:0] sum;       // two guard bits for four terms
    logic signed [22:0] scaled;    // back to integer after 4.4
    logic               over;
    logic               under;
    snd_pkg::sample_t   clamped;

    // gain is unsigned, zero-extend before the signed product
    function automatic logic signed [24:0] weigh(input snd_pkg::sample_t s,
                                                 input snd_pkg::gain_t g);
        return s * $signed({1'b0, g});
    endfunction

    assign prod0  = weigh(ch0, gain0);
    assign prod1  = weigh(ch1, gain1);
    assign prod2  = weigh(ch2, gain2);
    assign prod3  = weigh(ch3, gain3);
    assign sum    = prod0 + prod1 + prod2 + prod3;
    assign scaled = sum[26:4];    // drop the fraction

    always_comb begin
        over    = scaled > 23'sd32767;
        under   = scaled < -23'sd32768;
        clamped = scaled[15:0];
        if (over) begin
            clamped = 16'sh7fff;
        end else if (under) begin
            clamped = 16'sh8000;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mixed <= '0;
            peak  <= 1'b0;
        end else if (cen) begin
            mixed <= clamped;
            peak  <= over | under;   // held for the whole sample
        end
    end

endmodule

/* logic/snd_dc_block.sv */
// dc removal for a unipolar psg; output settles within about 32 lsb of zero for a constant input
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_dc_block (
    input  logic             clk,
    input  logic             rst,
    input  logic             sample,   // update strobe
    input  snd_pkg::psg_t    din,
    output snd_pkg::sample_t dout
);
    localparam logic signed [16:0] round_half = 17'sd1 <<< (`SND_DC_SHIFT - 1);

    logic signed [16:0] scaled;   // always positive
    logic signed [16:0] avg;      // running dc estimate
    logic signed [16:0] diff;
    logic signed [16:0] step;

    assign scaled = $signed(17'(din) << `SND_PSG_SCALE);
    assign diff   = scaled - avg;
    // rounded so the estimate creeps within half a step of the input
    assign step   = (diff + round_half) >>> `SND_DC_SHIFT;

    always_ff @(posedge clk) begin
        if (rst) begin
            avg  <= '0;
            dout <= '0;
        end else if (sample) begin
            dout <= diff[15:0];   // fits, avg never leaves 0..scaled max
            avg  <= avg + step;
        end
    end

endmodule

/* logic/snd_work_ram.sv */
// work RAM without reset, contents undefined at power up; read data is one clock late
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_work_ram (
    input  logic                    clk,
    input  logic [`SND_RAM_AW-1:0]  addr,
    input  snd_pkg::cpu_data_t      din,
    input  logic                    we,
    output snd_pkg::cpu_data_t      dout
);
    localparam int depth = 1 << `SND_RAM_AW;

    snd_pkg::cpu_data_t mem [depth];

    // write first, new byte shows on dout
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
            dout      <= din;
        end else begin
            dout <= mem[addr];  // registered read
        end
    end

endmodule

/* logic/snd_sys_regs.sv */
// NMI latch, bank bit and ADPCM enable; cen_opl must be a single-clock strobe
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_sys_regs (
    input  logic clk,
    input  logic rst,
    input  logic snreq,      // sound request level from the main CPU
    input  logic nmi_clr,    // latch read strobe
    input  logic bank_we,
    input  logic bank_din,
    input  logic cen_opl,
    output logic nmin,
    output logic snd_bank,
    output logic cen_oki     // one pulse per SND_OKI_DIV opl enables
);
    logic                    snreq_l;    // last sampled request
    logic [`SND_OKI_DIV-1:0] oki_ring;   // one-hot divider

    // nmi set on request edge
    always_ff @(posedge clk) begin
        if (rst) begin
            snreq_l <= 1'b0;
            nmin    <= 1'b1;
        end else begin
            snreq_l <= snreq;
            if (nmi_clr) begin
                nmin <= 1'b1;               // ack beats a new request
            end else if (snreq && !snreq_l) begin
                nmin <= 1'b0;
            end
        end
    end

    // bank select bit for the ROM upper half
    always_ff @(posedge clk) begin
        if (rst) begin
            snd_bank <= 1'b0;
        end else if (bank_we) begin
            snd_bank <= bank_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            oki_ring <= {{(`SND_OKI_DIV-1){1'b0}}, 1'b1};
            cen_oki  <= 1'b0;
        end else begin
            if (cen_opl) begin
                oki_ring <= {oki_ring[`SND_OKI_DIV-2:0], oki_ring[`SND_OKI_DIV-1]};
            end
            cen_oki <= cen_opl & oki_ring[0];   // fires on 1st, 4th, 7th...
        end
    end

endmodule

/* logic/snd_bus_decode.sv */
// single master decode for the sound CPU; chip bytes arrive one clock late, ROM bytes same cycle
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_bus_decode (
    input  logic               clk,
    input  logic               rst,
    input  snd_pkg::cpu_addr_t cpu_addr,
    input  logic               cpu_rnw,    // high on reads
    input  snd_pkg::cpu_data_t rom_data,
    input  snd_pkg::cpu_data_t ram_dout,
    input  snd_pkg::cpu_data_t latch,      // byte from the main CPU
    input  snd_pkg::cpu_data_t opn_dout,
    input  snd_pkg::cpu_data_t opl_dout,
    input  snd_pkg::cpu_data_t oki_dout,
    input  logic               rom_ok,
    input  logic               has_bank,   // level tied at the top
    output snd_pkg::cpu_data_t cpu_din,
    output logic               rom_cs,
    output logic               ram_we,
    output logic               opn_cs,
    output logic               opl_cs,
    output logic               oki_cs,
    output logic               oki_wrn,    // active low
    output logic               nmi_clr,
    output logic               bank_we,
    output logic               rdy
);
    snd_pkg::region_t   region;
    logic               ram_cs;
    logic               dev_cs;     // some chip selected last clock
    snd_pkg::cpu_data_t dev_mux;    // that chip's byte

    always_comb begin
        region = snd_pkg::rgn_none;
        if (|cpu_addr[15:14]) begin
            region = snd_pkg::rgn_rom;  // some boards only wire bit 15
        end else begin
            case (cpu_addr[13:11])
                `SND_RGN_RAM:   region = snd_pkg::rgn_ram;
                `SND_RGN_OPN:   region = snd_pkg::rgn_opn;
                `SND_RGN_OPL:   region = snd_pkg::rgn_opl;
                `SND_RGN_LATCH: region = cpu_rnw ? snd_pkg::rgn_nmi_clr : snd_pkg::rgn_none;
                `SND_RGN_OKI:   region = snd_pkg::rgn_oki;
                default:        region = snd_pkg::rgn_none;  // 3..5 are holes
            endcase
        end
    end

    assign rom_cs  = region == snd_pkg::rgn_rom;
    assign ram_cs  = region == snd_pkg::rgn_ram;
    assign opn_cs  = region == snd_pkg::rgn_opn;
    assign opl_cs  = region == snd_pkg::rgn_opl;
    assign oki_cs  = region == snd_pkg::rgn_oki;
    assign nmi_clr = region == snd_pkg::rgn_nmi_clr;
    assign ram_we  = ram_cs & ~cpu_rnw;
    assign oki_wrn = ~(oki_cs & ~cpu_rnw);
    assign bank_we = has_bank & cpu_addr[15] & ~cpu_rnw;  // shares the ROM space
    assign rdy     = ~rom_cs | rom_ok;   // only ROM fetches stall

    // chip read stage, reloaded every clock
    always_ff @(posedge clk) begin
        if (rst) begin
            dev_cs <= 1'b0;
        end else begin
            dev_cs <= opn_cs | opl_cs | oki_cs;
        end
    end

    always_ff @(posedge clk) begin
        dev_mux <= opn_cs ? opn_dout : opl_cs ? opl_dout : oki_dout;  // opn first
    end

    always_comb begin
        if (rom_cs)       cpu_din = rom_data;
        else if (ram_cs)  cpu_din = ram_dout;
        else if (nmi_clr) cpu_din = latch;
        else if (dev_cs)  cpu_din = dev_mux;
        else              cpu_din = 8'hff;   // open bus
    end

endmodule

/* logic/snd_pkg.sv */
// shared bus and audio types for the sound board; widths fixed for a 6502 bus and 16-bit audio
package snd_pkg;

    // sound CPU address bus, 64 KB space
    typedef logic [15:0] cpu_addr_t;

    // sound CPU data byte, shared by all chip buses
    typedef logic [7:0] cpu_data_t;

    // two's complement audio sample at the mixer
    typedef logic signed [15:0] sample_t;

    // raw PSG output from the OPN, unsigned with a large DC offset
    typedef logic [9:0] psg_t;

    // channel gain, 4.4 fixed point
    // 8'h10 is unity, 8'h08 is half
    typedef logic [7:0] gain_t;

    // decoded region of the current CPU address
    typedef enum logic [2:0] {
        rgn_ram,        // 2 KB work RAM
        rgn_opn,        // OPN type FM chip
        rgn_opl,        // OPL type FM chip
        rgn_nmi_clr,    // sound latch read, also acks the NMI
        rgn_oki,        // ADPCM chip
        rgn_rom,        // program ROM, bits 15..14 not both zero
        rgn_none        // unmapped, reads as 8'hff
    } region_t;

    // the bank register sits on top of the ROM writes
    // so it has no region of its own
    // the latch region only decodes on reads
    // a write there falls to rgn_none

endpackage

/* logic/snd_macros.svh */
// board constants only; region codes are for address bits 13..11 with bits 15..14 clear
`ifndef SND_MACROS_SVH
`define SND_MACROS_SVH

// region codes on address bits 13..11
`define SND_RGN_RAM     3'd0
`define SND_RGN_OPN     3'd1
`define SND_RGN_OPL     3'd2
`define SND_RGN_LATCH   3'd6
`define SND_RGN_OKI     3'd7

`define SND_RAM_AW      11      // 2 KB work RAM

// channel gains in 4.4, 8'h10 is unity
`define SND_OPN_GAIN    8'h10
`define SND_OPL_GAIN    8'h10
`define SND_PCM_GAIN    8'h10
`define SND_PSG_GAIN    8'h10

// dc filter time constant, roughly 64 samples
`define SND_DC_SHIFT    6
`define SND_PSG_SCALE   5       // 10-bit psg up to 15 bits

`define SND_OKI_DIV     3       // opl enable divided down for the ADPCM

`endif
